//--- vlog.f
src/usb_demo_pkg.sv
src/telemetry_pkg.sv
src/bulk_loop_fifo.sv
src/endpoint_status.sv
src/hex_dump.sv
src/uart_tx.sv
src/usb_demo_top.sv
test/usb_demo_checker.sv
test/usb_demo_assert.sv
test/usb_demo_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run with Verilator, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module usb_demo_tb \
  -f vlog.f -o usb_demo_sim > build.log 2>&1 \
  && ./obj_dir/usb_demo_sim > sim.log 2>&1 \
  || echo "Build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && exit 0 || exit 1

//--- test/usb_demo_tb.sv
`timescale 1ns/1ns
`default_nettype none

module usb_demo_tb;

  localparam int WAIT_LIMIT = 5000;

  typedef struct {
    int         len;
    logic [7:0] first;
    bit         drain;
    int         sofs;
    int         crcs;
    int         tmos;
    bit         dump;
  } entry_t;

  logic clock = 1'b0;
  logic usb_reset = 1'b1;
  logic configured_i = 1'b0;
  logic blk_cycle_i = 1'b0;
  logic crc_error_i = 1'b0;
  logic timeout_i = 1'b0;
  logic sof_i = 1'b0;
  logic send_i = 1'b0;
  logic out_valid_i = 1'b0;
  logic out_last_i = 1'b0;
  logic [7:0] out_data_i = 8'h00;
  logic in_ready_i = 1'b0;
  wire out_ready_o;
  wire in_valid_o;
  wire in_last_o;
  wire [7:0] in_data_o;
  wire blk_in_ready_o;
  wire blk_out_ready_o;
  wire dumping_o;
  wire uart_tx_o;
  wire [3:0] leds_o;

  integer seed = 32'h5151;
  logic [31:0] rnd_q = 32'h0;
  int timeouts = 0;
  bit draining = 1'b0;
  entry_t stim [5];

  always #2 clock = ~clock;

  usb_demo_top uut (.*);

  usb_demo_checker u_checker (.*);

  // Random transfer-cycle gaps, IN back-pressure and OUT stream values
  always @(posedge clock) begin
    rnd_q       <= $random(seed);
    blk_cycle_i <= ($random(seed) & 7) != 0;
    in_ready_i  <= draining && (($random(seed) & 3) != 0);
  end

  task automatic send_packet(input int len, input logic [7:0] first);
    int cnt;
    for (int i = 0; i < len; i++) begin
      if (rnd_q[1:0] == 2'd0) begin
        out_valid_i <= 1'b0;
        @(posedge clock);
      end
      out_valid_i <= 1'b1;
      out_data_i  <= (i == 0) ? first : rnd_q[15:8];
      out_last_i  <= (i == len - 1) || (i % 64 == 63);
      cnt = 0;
      do begin
        @(posedge clock);
        cnt++;
      end while (!(out_ready_o && blk_cycle_i) && cnt < WAIT_LIMIT);
      if (cnt >= WAIT_LIMIT) begin
        timeouts++;
        $display("Timeout waiting for an OUT byte to be accepted");
      end
    end
    out_valid_i <= 1'b0;
  endtask

  task automatic drain_fifo();
    int cnt;
    draining <= 1'b1;
    cnt = 0;
    while ((u_checker.out_q.size() != 0 || in_valid_o) && cnt < WAIT_LIMIT * 4) begin
      @(posedge clock);
      cnt++;
    end
    if (cnt >= WAIT_LIMIT * 4) begin
      timeouts++;
      $display("Timeout waiting for the FIFO to drain");
    end
    draining <= 1'b0;
  endtask

  // which: 0 SOF, 1 CRC error, 2 timeout
  task automatic pulse_inputs(input int n, input int which);
    repeat (n) begin
      case (which)
        0: sof_i <= 1'b1;
        1: crc_error_i <= 1'b1;
        default: timeout_i <= 1'b1;
      endcase
      @(posedge clock);
      sof_i       <= 1'b0;
      crc_error_i <= 1'b0;
      timeout_i   <= 1'b0;
      @(posedge clock);
    end
  endtask

  task automatic run_dump();
    int cnt;
    send_i <= 1'b1;
    @(posedge clock);
    send_i <= 1'b0;
    // Record goes out until the newline has been decoded
    @(negedge clock);
    cnt = 0;
    while ((dumping_o || u_checker.exp_chars.size() != 0) && cnt < WAIT_LIMIT) begin
      @(negedge clock);
      cnt++;
    end
    if (cnt >= WAIT_LIMIT) begin
      timeouts++;
      $display("Timeout waiting for the telemetry dump to finish");
    end
    @(posedge clock);
  endtask

  initial begin
    stim[0] = '{16, 8'h10, 1, 2, 0, 0, 1};
    stim[1] = '{40, 8'hA5, 0, 1, 0, 0, 1};
    // Tops the FIFO up to its full depth
    stim[2] = '{984, 8'h3C, 0, 0, 1, 0, 1};
    stim[3] = '{0, 8'h00, 1, 3, 0, 1, 1};
    stim[4] = '{200, 8'h7E, 1, 1, 1, 0, 0};

    repeat (16) @(posedge clock);
    usb_reset <= 1'b0;
    repeat (8) @(posedge clock);
    configured_i <= 1'b1;
    repeat (4) @(posedge clock);

    foreach (stim[i]) begin
      send_packet(stim[i].len, stim[i].first);
      if (stim[i].drain) drain_fifo();
      repeat (4) @(posedge clock);
      pulse_inputs(stim[i].sofs, 0);
      pulse_inputs(stim[i].crcs, 1);
      pulse_inputs(stim[i].tmos, 2);
      repeat (4) @(posedge clock);
      if (stim[i].dump) run_dump();
    end
    repeat (8) @(posedge clock);

    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             u_checker.checks, u_checker.errors, uut.u_assert.fail_count, timeouts);
    if (u_checker.errors == 0 && uut.u_assert.fail_count == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/usb_demo_assert.sv
`timescale 1ns/1ns
`default_nettype none

module usb_demo_assert (
  input wire clock,
  input wire usb_reset,
  input wire configured_i,
  input wire blk_in_ready_o,
  input wire blk_out_ready_o,
  input wire uart_tx_o
);

  int fail_count = 0;

  // Unconfigured endpoint withdraws both flags on the next cycle
  ready_needs_config: assert property (@(posedge clock) disable iff (usb_reset)
    !configured_i |=> (!blk_in_ready_o && !blk_out_ready_o))
    else begin
      $error("ready flag set one cycle after configured_i was low");
      fail_count++;
    end

  // Serial line idles high while in reset
  line_idle_in_reset: assert property (@(posedge clock)
    usb_reset |=> uart_tx_o)
    else begin
      $error("uart_tx_o low during reset");
      fail_count++;
    end

endmodule

bind usb_demo_top usb_demo_assert u_assert (.*);

`default_nettype wire

//--- test/usb_demo_checker.sv
`timescale 1ns/1ns
`default_nettype none

module usb_demo_checker (
  input wire       clock,
  input wire       usb_reset,
  input wire       configured_i,
  input wire       blk_cycle_i,
  input wire       crc_error_i,
  input wire       timeout_i,
  input wire       sof_i,
  input wire       send_i,
  input wire       out_valid_i,
  input wire       out_ready_o,
  input wire       out_last_i,
  input wire [7:0] out_data_i,
  input wire       in_valid_o,
  input wire       in_ready_i,
  input wire       in_last_o,
  input wire [7:0] in_data_o,
  input wire       blk_in_ready_o,
  input wire       blk_out_ready_o,
  input wire       dumping_o,
  input wire       uart_tx_o,
  input wire [3:0] leds_o
);

  import usb_demo_pkg::*;
  import telemetry_pkg::*;

  int checks = 0;
  int errors = 0;
  logic [8:0] out_q[$];
  logic [7:0] exp_chars[$];

  int level_m;
  int quiet_cnt;
  int frame_m;
  logic crc_m;
  logic tmo_m;
  logic cfg_prev;
  logic sof_prev;
  logic rst_prev = 1'b1;

  int rx_timer;
  int rx_idx;
  logic rx_busy;
  logic rx_prev;
  logic [7:0] rx_byte;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Expected record and its nine characters at capture time
  task automatic queue_dump();
    telemetry_word_t rec;
    logic [3:0] nib;
    rec.fields.frame_count     = frame_m[FRAME_BITS-1:0];
    rec.fields.fifo_level      = level_m[LEVEL_BITS-1:0];
    rec.fields.configured      = cfg_prev;
    rec.fields.crc_latched     = crc_m;
    rec.fields.timeout_latched = tmo_m;
    rec.fields.in_ready        = cfg_prev && (level_m > IN_READY_MIN);
    rec.fields.out_ready       = cfg_prev && (level_m < OUT_READY_LIMIT);
    for (int n = 7; n >= 0; n--) begin
      nib = rec[n*4 +: 4];
      exp_chars.push_back((nib < 10) ? 8'h30 + nib : 8'h41 + nib - 10);
    end
    exp_chars.push_back(8'h0A);
  endtask

  // UART sampler, mid-bit after the start edge
  task automatic sample_uart();
    if (!rx_busy) begin
      if (rx_prev && !uart_tx_o) begin
        rx_busy  = 1'b1;
        rx_timer = 0;
      end
    end else begin
      rx_timer++;
      if (rx_timer % UART_BIT_CYCLES == UART_BIT_CYCLES / 2) begin
        rx_idx = rx_timer / UART_BIT_CYCLES;
        if (rx_idx >= 1 && rx_idx <= 8) begin
          rx_byte[rx_idx-1] = uart_tx_o;
        end else if (rx_idx == 9) begin
          rx_busy = 1'b0;
          check_val("uart_tx_o stop bit", uart_tx_o, 1);
          if (exp_chars.size() == 0) begin
            errors++;
            $display("UART sent a character that no dump requested");
          end else begin
            check_val("uart character", rx_byte, exp_chars.pop_front());
          end
        end
      end
    end
    rx_prev = uart_tx_o;
  endtask

  always @(posedge clock) begin
    logic fire_out;
    logic fire_in;
    logic [8:0] exp_entry;
    if (usb_reset) begin
      out_q.delete();
      exp_chars.delete();
      level_m   = 0;
      quiet_cnt = 0;
      frame_m   = 0;
      crc_m     = 1'b0;
      tmo_m     = 1'b0;
      cfg_prev  = 1'b0;
      sof_prev  = 1'b0;
      rx_busy   = 1'b0;
      rx_prev   = 1'b1;
    end else begin
      if (rst_prev) begin
        check_val("in_valid_o", in_valid_o, 0);
        check_val("blk_in_ready_o", blk_in_ready_o, 0);
        check_val("blk_out_ready_o", blk_out_ready_o, 0);
        check_val("leds_o", leds_o, 0);
        check_val("uart_tx_o", uart_tx_o, 1);
      end
      fire_out = out_valid_i && out_ready_o && blk_cycle_i;
      fire_in  = in_valid_o && in_ready_i && blk_cycle_i;

      check_val("out_ready_o", out_ready_o, level_m < FIFO_DEPTH);
      check_val("leds_o[3]", leds_o[3], crc_m);
      check_val("leds_o[2]", leds_o[2], tmo_m);
      check_val("leds_o[0]", leds_o[0], cfg_prev);
      if (quiet_cnt >= 2) begin
        check_val("blk_in_ready_o", blk_in_ready_o, cfg_prev && (level_m > IN_READY_MIN));
        check_val("blk_out_ready_o", blk_out_ready_o, cfg_prev && (level_m < OUT_READY_LIMIT));
        check_val("leds_o[1]", leds_o[1], cfg_prev && (level_m > IN_READY_MIN));
      end

      // Busy while hex digits remain, idle once the newline is decoded
      if (exp_chars.size() != 1) begin
        check_val("dumping_o", dumping_o, exp_chars.size() > 1);
      end

      if (send_i && !dumping_o) queue_dump();

      if (fire_in) begin
        if (out_q.size() == 0) begin
          errors++;
          $display("IN stream delivered a byte that was never written");
        end else begin
          exp_entry = out_q.pop_front();
          check_val("in_data_o", in_data_o, exp_entry[7:0]);
          check_val("in_last_o", in_last_o, exp_entry[8]);
        end
        level_m--;
      end
      if (fire_out) begin
        out_q.push_back({out_last_i, out_data_i});
        level_m++;
      end
      quiet_cnt = (fire_in || fire_out) ? 0 : quiet_cnt + 1;

      if (crc_error_i) crc_m = 1'b1;
      if (timeout_i) tmo_m = 1'b1;
      if (sof_i && !sof_prev) frame_m++;
      sof_prev = sof_i;
      cfg_prev = configured_i;

      sample_uart();
    end
    rst_prev = usb_reset;
  end

endmodule

`default_nettype wire

//--- src/usb_demo_top.sv
`timescale 1ns/1ns
`default_nettype none

module usb_demo_top (
  input  wire        clock,
  input  wire        usb_reset,

  // Status from the protocol core
  input  wire        configured_i,
  input  wire        blk_cycle_i,
  input  wire        crc_error_i,
  input  wire        timeout_i,
  input  wire        sof_i,
  input  wire        send_i,

  // Bulk OUT stream
  input  wire        out_valid_i,
  output logic       out_ready_o,
  input  wire        out_last_i,
  input  wire  [7:0] out_data_i,

  // Bulk IN stream
  output logic       in_valid_o,
  input  wire        in_ready_i,
  output logic       in_last_o,
  output logic [7:0] in_data_o,

  output logic       blk_in_ready_o,
  output logic       blk_out_ready_o,
  output logic       dumping_o,
  output logic       uart_tx_o,
  output logic [3:0] leds_o
);

  import usb_demo_pkg::*;
  import telemetry_pkg::*;

  logic [LEVEL_BITS-1:0] level_w;
  telemetry_word_t record_w;

  logic tx_valid;
  logic tx_ready;
  logic [7:0] tx_data;

  // Loopback from OUT to IN
  bulk_loop_fifo u_fifo (
    .clock      (clock),
    .usb_reset  (usb_reset),
    .blk_cycle_i(blk_cycle_i),
    .wr_valid_i (out_valid_i),
    .wr_last_i  (out_last_i),
    .wr_data_i  (out_data_i),
    .wr_ready_o (out_ready_o),
    .rd_valid_o (in_valid_o),
    .rd_last_o  (in_last_o),
    .rd_data_o  (in_data_o),
    .rd_ready_i (in_ready_i),
    .level_o    (level_w)
  );

  endpoint_status u_status (
    .clock          (clock),
    .usb_reset      (usb_reset),
    .configured_i   (configured_i),
    .level_i        (level_w),
    .crc_error_i    (crc_error_i),
    .timeout_i      (timeout_i),
    .sof_i          (sof_i),
    .blk_in_ready_o (blk_in_ready_o),
    .blk_out_ready_o(blk_out_ready_o),
    .leds_o         (leds_o),
    .record_o       (record_w)
  );

  // Telemetry out through the serial port
  hex_dump u_hex_dump (
    .clock     (clock),
    .usb_reset (usb_reset),
    .send_i    (send_i),
    .record_i  (record_w),
    .dumping_o (dumping_o),
    .tx_valid_o(tx_valid),
    .tx_data_o (tx_data),
    .tx_ready_i(tx_ready)
  );

  uart_tx u_uart_tx (
    .clock     (clock),
    .usb_reset (usb_reset),
    .tx_valid_i(tx_valid),
    .tx_data_i (tx_data),
    .tx_ready_o(tx_ready),
    .uart_tx_o (uart_tx_o)
  );

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  wire        clock,
  input  wire        usb_reset,
  input  wire        tx_valid_i,
  input  wire  [7:0] tx_data_i,
  output logic       tx_ready_o,
  output logic       uart_tx_o
);

  import telemetry_pkg::*;

  // Data bits with the stop bit behind them
  logic [8:0] shift_q;
  logic [$clog2(UART_BIT_CYCLES)-1:0] bit_timer_q;
  logic [3:0] bit_cnt_q;
  logic busy_q;
  logic line_q;
  logic bit_end;

  assign bit_end = (bit_timer_q == UART_BIT_CYCLES - 1);

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      busy_q      <= 1'b0;
      line_q      <= 1'b1;
      bit_timer_q <= '0;
      bit_cnt_q   <= '0;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        // Start bit goes out straight away
        busy_q      <= 1'b1;
        line_q      <= 1'b0;
        shift_q     <= {1'b1, tx_data_i};
        bit_timer_q <= '0;
        bit_cnt_q   <= '0;
      end
    end else begin
      bit_timer_q <= bit_timer_q + 1'b1;
      if (bit_end) begin
        bit_timer_q <= '0;
        if (bit_cnt_q == 4'd9) begin
          // Stop bit done
          busy_q <= 1'b0;
        end else begin
          line_q    <= shift_q[0];
          shift_q   <= {1'b1, shift_q[8:1]};
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  assign tx_ready_o = !busy_q;
  assign uart_tx_o  = line_q;

endmodule

`default_nettype wire

//--- src/hex_dump.sv
`timescale 1ns/1ns
`default_nettype none

module hex_dump (
  input  wire                             clock,
  input  wire                             usb_reset,
  input  wire                             send_i,
  input  wire telemetry_pkg::telemetry_word_t record_i,
  output logic                            dumping_o,
  output logic                            tx_valid_o,
  output logic [7:0]                      tx_data_o,
  input  wire                             tx_ready_i
);

  import telemetry_pkg::*;

  telemetry_word_t snapshot_q;
  logic busy_q;
  logic [$clog2(DUMP_CHARS)-1:0] char_cnt_q;

  logic [1:0] byte_idx;
  logic [7:0] cur_byte;
  logic [3:0] nibble;
  logic last_char;
  logic tx_fire;

  // ASCII upper-case hex digit
  function automatic logic [7:0] hex_char(input logic [3:0] value);
    logic [7:0] base;
    base = (value < 4'd10) ? 8'h30 : 8'h37;
    return base + {4'h0, value};
  endfunction

  // Two characters per byte, most significant byte first
  assign byte_idx = 2'd3 - char_cnt_q[2:1];
  assign cur_byte = snapshot_q.bytes[byte_idx];
  assign nibble   = char_cnt_q[0] ? cur_byte[3:0] : cur_byte[7:4];

  assign last_char = (char_cnt_q == DUMP_CHARS - 1);
  assign tx_fire   = busy_q && tx_ready_i;

  // Snapshot is plain payload, only loaded on capture
  always_ff @(posedge clock) begin
    if (!busy_q && send_i) begin
      snapshot_q <= record_i;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      busy_q     <= 1'b0;
      char_cnt_q <= '0;
    end else if (!busy_q) begin
      if (send_i) begin
        busy_q     <= 1'b1;
        char_cnt_q <= '0;
      end
    end else if (tx_fire) begin
      if (last_char) begin
        busy_q <= 1'b0;
      end else begin
        char_cnt_q <= char_cnt_q + 1'b1;
      end
    end
  end

  assign dumping_o  = busy_q;
  assign tx_valid_o = busy_q;

  // Newline closes each record
  assign tx_data_o = last_char ? 8'h0A : hex_char(nibble);

endmodule

`default_nettype wire

//--- src/endpoint_status.sv
`timescale 1ns/1ns
`default_nettype none

module endpoint_status (
  input  wire                                   clock,
  input  wire                                   usb_reset,
  input  wire                                   configured_i,
  input  wire  [usb_demo_pkg::LEVEL_BITS-1:0]   level_i,
  input  wire                                   crc_error_i,
  input  wire                                   timeout_i,
  input  wire                                   sof_i,
  output logic                                  blk_in_ready_o,
  output logic                                  blk_out_ready_o,
  output logic [3:0]                            leds_o,
  output telemetry_pkg::telemetry_word_t        record_o
);

  import usb_demo_pkg::*;

  logic configured_q;
  logic in_ready_q;
  logic out_ready_q;
  logic crc_latched_q;
  logic timeout_latched_q;
  logic sof_q;
  logic [FRAME_BITS-1:0] frame_count_q;

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      configured_q      <= 1'b0;
      in_ready_q        <= 1'b0;
      out_ready_q       <= 1'b0;
      crc_latched_q     <= 1'b0;
      timeout_latched_q <= 1'b0;
      sof_q             <= 1'b0;
      frame_count_q     <= '0;
    end else begin
      configured_q <= configured_i;

      // Readiness follows the FIFO level one cycle late
      in_ready_q  <= configured_i && (level_i > IN_READY_MIN);
      out_ready_q <= configured_i && (level_i < OUT_READY_LIMIT);

      // Sticky until the next bus reset
      if (crc_error_i) crc_latched_q <= 1'b1;
      if (timeout_i) timeout_latched_q <= 1'b1;

      // Count rising edges of the SOF strobe
      sof_q <= sof_i;
      if (sof_i && !sof_q) begin
        frame_count_q <= frame_count_q + 1'b1;
      end
    end
  end

  assign blk_in_ready_o  = in_ready_q;
  assign blk_out_ready_o = out_ready_q;

  assign leds_o = {crc_latched_q, timeout_latched_q, in_ready_q, configured_q};

  always_comb begin
    record_o.fields.frame_count     = frame_count_q;
    record_o.fields.fifo_level      = level_i;
    record_o.fields.configured      = configured_q;
    record_o.fields.crc_latched     = crc_latched_q;
    record_o.fields.timeout_latched = timeout_latched_q;
    record_o.fields.in_ready        = in_ready_q;
    record_o.fields.out_ready       = out_ready_q;
  end

endmodule

`default_nettype wire

//--- src/bulk_loop_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module bulk_loop_fifo (
  input  wire                                 clock,
  input  wire                                 usb_reset,
  input  wire                                 blk_cycle_i,
  input  wire                                 wr_valid_i,
  input  wire                                 wr_last_i,
  input  wire  [7:0]                          wr_data_i,
  output logic                                wr_ready_o,
  output logic                                rd_valid_o,
  output logic                                rd_last_o,
  output logic [7:0]                          rd_data_o,
  input  wire                                 rd_ready_i,
  output logic [usb_demo_pkg::LEVEL_BITS-1:0] level_o
);

  import usb_demo_pkg::*;

  // Each entry is {last, data}
  logic [8:0] mem [FIFO_DEPTH];

  // Extra MSB tells wrap-around apart
  logic [FIFO_ABITS:0] wr_ptr_q;
  logic [FIFO_ABITS:0] rd_ptr_q;
  logic [LEVEL_BITS-1:0] level_q;
  logic rd_valid_q;
  logic rd_last_q;
  logic [7:0] rd_data_q;

  logic wr_fire;
  logic rd_fire;
  logic mem_empty;
  logic load;

  // Both streams only move during an endpoint transfer cycle
  assign wr_fire = wr_valid_i && wr_ready_o && blk_cycle_i;
  assign rd_fire = rd_valid_q && rd_ready_i && blk_cycle_i;

  assign mem_empty = (wr_ptr_q == rd_ptr_q);

  // Refill the output stage when it is empty or being drained
  assign load = !mem_empty && (!rd_valid_q || rd_fire);

  // Level covers the array plus the output stage
  assign wr_ready_o = (level_q < FIFO_DEPTH);

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      mem[wr_ptr_q[FIFO_ABITS-1:0]] <= {wr_last_i, wr_data_i};
    end
    if (load) begin
      {rd_last_q, rd_data_q} <= mem[rd_ptr_q[FIFO_ABITS-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      rd_valid_q <= 1'b0;
      level_q    <= '0;
    end else begin
      if (wr_fire) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (load) begin
        rd_ptr_q   <= rd_ptr_q + 1'b1;
        rd_valid_q <= 1'b1;
      end else if (rd_fire) begin
        rd_valid_q <= 1'b0;
      end
      case ({wr_fire, rd_fire})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_last_o  = rd_last_q;
  assign rd_data_o  = rd_data_q;
  assign level_o    = level_q;

endmodule

`default_nettype wire

//--- src/telemetry_pkg.sv
`default_nettype none

package telemetry_pkg;

  // Status record as written by the register block, MSB first
  typedef struct packed {
    logic [usb_demo_pkg::FRAME_BITS-1:0] frame_count;
    logic [usb_demo_pkg::LEVEL_BITS-1:0] fifo_level;
    logic                                configured;
    logic                                crc_latched;
    logic                                timeout_latched;
    logic                                in_ready;
    logic                                out_ready;
  } telemetry_fields_t;

  // Same 32 bits, seen as bytes by the hex formatter
  typedef union packed {
    telemetry_fields_t fields;
    logic [3:0][7:0]   bytes;
  } telemetry_word_t;

  // Clocks per UART bit
  localparam int UART_BIT_CYCLES = 16;

  // Eight hex digits and a newline
  localparam int DUMP_CHARS = 9;

endpackage

`default_nettype wire

//--- src/usb_demo_pkg.sv
`default_nettype none

package usb_demo_pkg;

  // Loopback FIFO geometry
  localparam int FIFO_ABITS = 10;
  localparam int FIFO_DEPTH = 1024;

  // Level counter holds 0 to FIFO_DEPTH inclusive
  localparam int LEVEL_BITS = 11;

  // IN endpoint advertises data once more than this many bytes wait
  localparam int IN_READY_MIN = 4;

  // OUT endpoint stops accepting packets near the top of the FIFO,
  // leaving room for one more full-speed packet in flight
  localparam int OUT_READY_LIMIT = 960;

  // SOF counter width
  localparam int FRAME_BITS = 16;

endpackage

`default_nettype wire
